// File: compile.f
source/decode_pkg.sv
source/dispatch_pkg.sv
source/inst_decoder.sv
source/dispatch_buffer.sv
source/decode_dispatch.sv
sim/clock_gen.sv
sim/tb_decode_dispatch.sv

// File: run.sh
#!/bin/sh
# build and run the decode-dispatch testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decode_dispatch \
  -f compile.f -o tb_decode_dispatch

./obj_dir/tb_decode_dispatch | tee sim.log

if grep -q "^TEST PASSED$" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: sim/tb_decode_dispatch.sv
//####################################################################
// testbench for the decode-and-dispatch stage
// a queue model of the buffer feeds expected controls to the checks
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_decode_dispatch;
  import decode_pkg::*;
  import dispatch_pkg::*;

  localparam int RAND_N         = 100;  // back-pressure stream length
  localparam int RAND_CYCLES    = 200;
  // reset, then at most one cycle per directed instruction, plus hold and random
  localparam int STIM_CYCLES    = 5 + 33 + 17 + 6 + 8 + 5 + RAND_CYCLES + RAND_N;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  typedef struct packed {
    opa_sel_t  opa_select;
    opb_sel_t  opb_select;
    alu_func_t alu_func;
    reg_idx_t  ra_idx, rb_idx, dest_idx;
    logic      rd_mem, wr_mem, ldl_mem, stc_mem;
    logic      cond_branch, uncond_branch, halt, illegal;
  } ctrl_t;

  // alu code number -> group and function field
  localparam opcode_t GRP_OF [17] = '{INTA_GRP, INTA_GRP, INTA_GRP, INTA_GRP, INTA_GRP,
    INTA_GRP, INTA_GRP, INTL_GRP, INTL_GRP, INTL_GRP, INTL_GRP, INTL_GRP, INTL_GRP,
    INTS_GRP, INTS_GRP, INTS_GRP, INTM_GRP};
  localparam int_func_t CODE_OF [17] = '{ADDQ_INST, SUBQ_INST, CMPEQ_INST, CMPLT_INST,
    CMPLE_INST, CMPULT_INST, CMPULE_INST, AND_INST, BIC_INST, BIS_INST, ORNOT_INST,
    XOR_INST, EQV_INST, SRL_INST, SLL_INST, SRA_INST, MULQ_INST};
  localparam opcode_t MEM_BR_OPS [7] = '{LDA_INST, LDQ_INST, LDQ_L_INST, STQ_INST,
    STQ_C_INST, BR_INST, BSR_INST};
  localparam opcode_t BAD_OPS [11] = '{FBEQ_INST, FBLT_INST, FBLE_INST, FBNE_INST,
    FBGE_INST, FBGT_INST, 6'h01, 6'h09, 6'h14, 6'h28, 6'h2c};  // fp branches and unused groups
  localparam opcode_t RAND_OPS [16] = '{INTA_GRP, INTL_GRP, INTS_GRP, INTM_GRP, JSR_GRP,
    LDA_INST, LDQ_INST, LDQ_L_INST, STQ_INST, STQ_C_INST, BR_INST, BSR_INST, FBGT_INST,
    6'h39, 6'h3e, 6'h14};

  logic        clock, reset;
  inst_t       inst0, inst1;
  logic        valid0, valid1;
  slot_count_t rob_free, rs_free, dispatch_count, fetch_request;
  opa_sel_t    out0_opa_select, out1_opa_select;
  opb_sel_t    out0_opb_select, out1_opb_select;
  alu_func_t   out0_alu_func, out1_alu_func;
  reg_idx_t    out0_ra_idx, out0_rb_idx, out0_dest_idx;
  reg_idx_t    out1_ra_idx, out1_rb_idx, out1_dest_idx;
  logic        out0_rd_mem, out0_wr_mem, out0_ldl_mem, out0_stc_mem;
  logic        out0_cond_branch, out0_uncond_branch, out0_halt, out0_illegal;
  logic        out1_rd_mem, out1_wr_mem, out1_ldl_mem, out1_stc_mem;
  logic        out1_cond_branch, out1_uncond_branch, out1_halt, out1_illegal;

  inst_t       stream_q [$];  // fetch side, not yet accepted
  ctrl_t       model_q [$];   // expected buffer contents, [0] oldest
  ctrl_t       exp_out0, exp_out1, act_out0, act_out1;
  slot_count_t exp_dispatch_count, exp_fetch_request;
  int          exp_occ, seq, errors, test_errors, tests_run, tests_failed;
  int          dispatched, cycle_count;

  clock_gen u_clock_gen (.clock(clock), .reset(reset));

  decode_dispatch u_decode_dispatch (.*);

  assign act_out0 = {out0_opa_select, out0_opb_select, out0_alu_func, out0_ra_idx,
                     out0_rb_idx, out0_dest_idx, out0_rd_mem, out0_wr_mem, out0_ldl_mem,
                     out0_stc_mem, out0_cond_branch, out0_uncond_branch, out0_halt,
                     out0_illegal};
  assign act_out1 = {out1_opa_select, out1_opb_select, out1_alu_func, out1_ra_idx,
                     out1_rb_idx, out1_dest_idx, out1_rd_mem, out1_wr_mem, out1_ldl_mem,
                     out1_stc_mem, out1_cond_branch, out1_uncond_branch, out1_halt,
                     out1_illegal};

  function automatic int min3(input int a, input int b, input int c);
    int m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  assign exp_dispatch_count = slot_count_t'(min3(exp_occ, int'(rob_free), int'(rs_free)));
  assign exp_fetch_request  = slot_count_t'(BUFFER_DEPTH - exp_occ + int'(exp_dispatch_count));

  // reference decode, written from the instruction rules
  function automatic ctrl_t ref_decode(input inst_t inst);
    ctrl_t   c;
    opcode_t op;
    op = inst[31:26];
    c = '0;
    c.ra_idx   = inst[25:21];
    c.rb_idx   = inst[20:16];
    c.dest_idx = ZERO_REG;
    if (op inside {INTA_GRP, INTL_GRP, INTS_GRP, INTM_GRP})
    begin
      c.opb_select = inst[12] ? OPB_ALU_IMM : OPB_REGB;
      c.dest_idx   = inst[4:0];  // rc
      c.illegal    = 1'b1;       // until a table hit
      for (int i = 0; i < 17; i++)
        if (op == GRP_OF[i] && inst[11:5] == CODE_OF[i])
        begin
          c.alu_func = alu_func_t'(i);
          c.illegal  = 1'b0;
        end
    end
    else if (op == JSR_GRP)
    begin
      c.opa_select    = OPA_NOT3;
      c.alu_func      = ALU_AND;
      c.dest_idx      = c.ra_idx;
      c.uncond_branch = 1'b1;
    end
    else if (op inside {LDA_INST, LDQ_INST, LDQ_L_INST, STQ_INST, STQ_C_INST})
    begin
      c.opa_select = OPA_MEM_DISP;
      c.rd_mem     = op inside {LDQ_INST, LDQ_L_INST};
      c.wr_mem     = op inside {STQ_INST, STQ_C_INST};
      c.ldl_mem    = (op == LDQ_L_INST);
      c.stc_mem    = (op == STQ_C_INST);
      c.dest_idx   = c.wr_mem ? ZERO_REG : c.ra_idx;
    end
    else if (op == BR_INST || op == BSR_INST || op >= 6'h38)
    begin
      c.opa_select    = OPA_NPC;
      c.opb_select    = OPB_BR_DISP;
      c.uncond_branch = (op < 6'h38);
      c.cond_branch   = (op >= 6'h38);  // integer conditional range
      c.dest_idx      = c.uncond_branch ? c.ra_idx : ZERO_REG;
    end
    else if (op == PAL_INST && inst[25:0] == PAL_HALT)
      c.halt = 1'b1;
    else
      c.illegal = 1'b1;
    if (c.illegal)
    begin
      c = '0;
      c.ra_idx   = inst[25:21];
      c.rb_idx   = inst[20:16];
      c.dest_idx = ZERO_REG;
      c.illegal  = 1'b1;
    end
    return c;
  endfunction

  task automatic mismatch(input string name, input int expv, input int actv);
    $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, expv, actv);
    errors++;
  endtask

  task automatic compare_slot(input string s, input ctrl_t e, input ctrl_t a);
    if (e.opa_select != a.opa_select)
      mismatch({s, "_opa_select"}, int'(e.opa_select), int'(a.opa_select));
    if (e.opb_select != a.opb_select)
      mismatch({s, "_opb_select"}, int'(e.opb_select), int'(a.opb_select));
    if (e.alu_func != a.alu_func)
      mismatch({s, "_alu_func"}, int'(e.alu_func), int'(a.alu_func));
    if (e.ra_idx != a.ra_idx)
      mismatch({s, "_ra_idx"}, int'(e.ra_idx), int'(a.ra_idx));
    if (e.rb_idx != a.rb_idx)
      mismatch({s, "_rb_idx"}, int'(e.rb_idx), int'(a.rb_idx));
    if (e.dest_idx != a.dest_idx)
      mismatch({s, "_dest_idx"}, int'(e.dest_idx), int'(a.dest_idx));
    if (e.rd_mem != a.rd_mem)
      mismatch({s, "_rd_mem"}, int'(e.rd_mem), int'(a.rd_mem));
    if (e.wr_mem != a.wr_mem)
      mismatch({s, "_wr_mem"}, int'(e.wr_mem), int'(a.wr_mem));
    if (e.ldl_mem != a.ldl_mem)
      mismatch({s, "_ldl_mem"}, int'(e.ldl_mem), int'(a.ldl_mem));
    if (e.stc_mem != a.stc_mem)
      mismatch({s, "_stc_mem"}, int'(e.stc_mem), int'(a.stc_mem));
    if (e.cond_branch != a.cond_branch)
      mismatch({s, "_cond_branch"}, int'(e.cond_branch), int'(a.cond_branch));
    if (e.uncond_branch != a.uncond_branch)
      mismatch({s, "_uncond_branch"}, int'(e.uncond_branch), int'(a.uncond_branch));
    if (e.halt != a.halt)
      mismatch({s, "_halt"}, int'(e.halt), int'(a.halt));
    if (e.illegal != a.illegal)
      mismatch({s, "_illegal"}, int'(e.illegal), int'(a.illegal));
  endtask

  // sampled at the rising edge with inputs settled since the falling edge
  a_reset_dispatch: assert property (@(posedge clock) !reset && $past(reset)
    |-> dispatch_count == 2'd0)
    else mismatch("dispatch_count after reset", 0, int'(dispatch_count));
  a_reset_fetch: assert property (@(posedge clock) !reset && $past(reset)
    |-> fetch_request == 2'd2)
    else mismatch("fetch_request after reset", 2, int'(fetch_request));
  a_dispatch_count: assert property (@(posedge clock) disable iff (reset)
    dispatch_count == exp_dispatch_count)
    else mismatch("dispatch_count", int'(exp_dispatch_count), int'(dispatch_count));
  a_fetch_request: assert property (@(posedge clock) disable iff (reset)
    fetch_request == exp_fetch_request)
    else mismatch("fetch_request", int'(exp_fetch_request), int'(fetch_request));
  a_slot0: assert property (@(posedge clock) disable iff (reset)
    exp_dispatch_count >= 2'd1 |-> act_out0 == exp_out0)
    else compare_slot("out0", exp_out0, act_out0);
  a_slot1: assert property (@(posedge clock) disable iff (reset)
    exp_dispatch_count == 2'd2 |-> act_out1 == exp_out1)
    else compare_slot("out1", exp_out1, act_out1);

  always @(posedge clock)
  begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [20:0] rand21();
    logic [31:0] r;
    r = $urandom;
    return r[20:0];
  endfunction

  // sequence number rides in the ra field
  task automatic push_seq(input opcode_t op, input logic [20:0] rest);
    stream_q.push_back({op, seq[4:0], rest});
    seq++;
  endtask

  task automatic push_op(input opcode_t op, input int_func_t fn);
    logic [20:0] r;
    r = rand21();
    push_seq(op, {r[20:13], r[0], fn, r[4:0]});  // r[0] picks literal form
  endtask

  // replays the edge just passed with the inputs still applied
  task automatic advance_model();
    int dc, acc;
    dc  = min3(exp_occ, int'(rob_free), int'(rs_free));
    acc = min3(int'(valid0) + int'(valid1), BUFFER_DEPTH - exp_occ + dc, 2);
    repeat (dc) void'(model_q.pop_front());
    dispatched += dc;
    if (acc >= 1)
      model_q.push_back(ref_decode(inst0));
    if (acc == 2)
      model_q.push_back(ref_decode(inst1));
    repeat (acc) void'(stream_q.pop_front());
    exp_occ = model_q.size();
    if (exp_occ >= 1)
      exp_out0 = model_q[0];
    if (exp_occ == 2)
      exp_out1 = model_q[1];
  endtask

  task automatic cycle_step(input int max_valid, input slot_count_t rob, input slot_count_t rs);
    int n;
    n = (max_valid < stream_q.size()) ? max_valid : stream_q.size();
    valid0 = (n >= 1);
    valid1 = (n >= 2);
    inst0  = $urandom;  // junk on empty slots
    inst1  = $urandom;
    if (n >= 1)
      inst0 = stream_q[0];
    if (n >= 2)
      inst1 = stream_q[1];
    rob_free = rob;
    rs_free  = rs;
    @(negedge clock);
    advance_model();
  endtask

  task automatic drain();
    while (stream_q.size() > 0 || model_q.size() > 0)
      cycle_step(2, MAX_CAPACITY, MAX_CAPACITY);
  endtask

  task automatic finish_test(input string name);
    cycle_step(0, MAX_CAPACITY, MAX_CAPACITY);  // last dispatch gets checked
    tests_run++;
    if (errors == test_errors)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial
  begin
    void'($urandom(32'h3125_f012));
    inst0    = '0;
    inst1    = '0;
    valid0   = 1'b0;
    valid1   = 1'b0;
    rob_free = MAX_CAPACITY;
    rs_free  = MAX_CAPACITY;
    @(negedge reset);

    repeat (2) cycle_step(0, MAX_CAPACITY, MAX_CAPACITY);
    finish_test("reset");

    for (int i = 0; i < 17; i++)
      push_op(GRP_OF[i], CODE_OF[i]);
    push_seq(JSR_GRP, rand21());
    for (int i = 0; i < 7; i++)
      push_seq(MEM_BR_OPS[i], rand21());
    for (int op = 'h38; op <= 'h3f; op++)
      push_seq(opcode_t'(op), rand21());
    drain();
    finish_test("legal decode");

    push_op(INTA_GRP, 7'h7f);
    push_op(INTL_GRP, 7'h01);
    push_op(INTS_GRP, 7'h20);
    push_op(INTM_GRP, 7'h00);
    for (int i = 0; i < 11; i++)
      push_seq(BAD_OPS[i], rand21());
    stream_q.push_back({PAL_INST, 26'h0083});  // special call, not halt
    stream_q.push_back({PAL_INST, PAL_HALT});
    drain();
    finish_test("illegal and halt");

    repeat (3)
    begin
      push_op(INTA_GRP, SUBQ_INST);
      push_seq(LDQ_INST, rand21());
    end
    repeat (4) cycle_step(2, 2'd0, 2'd0);  // fills, then holds
    repeat (2) cycle_step(2, 2'd0, 2'd2);
    repeat (2) cycle_step(2, 2'd2, 2'd0);
    drain();
    finish_test("zero capacity");

    repeat (RAND_N) push_seq(RAND_OPS[$urandom_range(15, 0)], rand21());
    for (int c = 0; c < RAND_CYCLES && stream_q.size() > 0; c++)
      cycle_step(int'($urandom_range(2, 0)), slot_count_t'($urandom_range(2, 0)),
                 slot_count_t'($urandom_range(2, 0)));
    drain();
    finish_test("random order");

    $display("summary: %0d tests, %0d failed, %0d mismatches, %0d dispatched",
             tests_run, tests_failed, errors, dispatched);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
//####################################################################
// testbench clock and reset, 20 ns period, reset held for 3 cycles
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // 20 ns period
  end

  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;                // released between sampling edges
  end

endmodule

`default_nettype wire

// File: source/decode_dispatch.sv
//####################################################################
// decode-and-dispatch stage top, two slot decoders feeding the
// dispatch buffer; fetch and back end connect here
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module decode_dispatch (
  input  logic                      clock,
  input  logic                      reset,
  input  decode_pkg::inst_t         inst0,     // older slot
  input  logic                      valid0,
  input  decode_pkg::inst_t         inst1,
  input  logic                      valid1,    // only with valid0
  input  dispatch_pkg::slot_count_t rob_free,
  input  dispatch_pkg::slot_count_t rs_free,
  output dispatch_pkg::slot_count_t dispatch_count,
  output dispatch_pkg::slot_count_t fetch_request,
  output decode_pkg::opa_sel_t      out0_opa_select, out1_opa_select,
  output decode_pkg::opb_sel_t      out0_opb_select, out1_opb_select,
  output decode_pkg::alu_func_t     out0_alu_func, out1_alu_func,
  output decode_pkg::reg_idx_t      out0_ra_idx, out0_rb_idx, out0_dest_idx,
  output decode_pkg::reg_idx_t      out1_ra_idx, out1_rb_idx, out1_dest_idx,
  output logic                      out0_rd_mem, out0_wr_mem, out0_ldl_mem, out0_stc_mem,
  output logic                      out0_cond_branch, out0_uncond_branch, out0_halt,
  output logic                      out0_illegal,
  output logic                      out1_rd_mem, out1_wr_mem, out1_ldl_mem, out1_stc_mem,
  output logic                      out1_cond_branch, out1_uncond_branch, out1_halt,
  output logic                      out1_illegal
);
  import decode_pkg::*;

  // decoder outputs, named as the buffer inputs
  opa_sel_t  in0_opa_select, in1_opa_select;
  opb_sel_t  in0_opb_select, in1_opb_select;
  alu_func_t in0_alu_func, in1_alu_func;
  reg_idx_t  in0_ra_idx, in0_rb_idx, in0_dest_idx;
  reg_idx_t  in1_ra_idx, in1_rb_idx, in1_dest_idx;
  logic      in0_rd_mem, in0_wr_mem, in0_ldl_mem, in0_stc_mem;
  logic      in0_cond_branch, in0_uncond_branch, in0_halt, in0_illegal;
  logic      in1_rd_mem, in1_wr_mem, in1_ldl_mem, in1_stc_mem;
  logic      in1_cond_branch, in1_uncond_branch, in1_halt, in1_illegal;

  inst_decoder u_decoder0 (
    .inst(inst0), .inst_valid(valid0),
    .opa_select(in0_opa_select), .opb_select(in0_opb_select), .alu_func(in0_alu_func),
    .ra_idx(in0_ra_idx), .rb_idx(in0_rb_idx), .dest_idx(in0_dest_idx),
    .rd_mem(in0_rd_mem), .wr_mem(in0_wr_mem), .ldl_mem(in0_ldl_mem), .stc_mem(in0_stc_mem),
    .cond_branch(in0_cond_branch), .uncond_branch(in0_uncond_branch),
    .halt(in0_halt), .illegal(in0_illegal)
  );

  inst_decoder u_decoder1 (
    .inst(inst1), .inst_valid(valid1),
    .opa_select(in1_opa_select), .opb_select(in1_opb_select), .alu_func(in1_alu_func),
    .ra_idx(in1_ra_idx), .rb_idx(in1_rb_idx), .dest_idx(in1_dest_idx),
    .rd_mem(in1_rd_mem), .wr_mem(in1_wr_mem), .ldl_mem(in1_ldl_mem), .stc_mem(in1_stc_mem),
    .cond_branch(in1_cond_branch), .uncond_branch(in1_uncond_branch),
    .halt(in1_halt), .illegal(in1_illegal)
  );

  // remaining ports match by name
  dispatch_buffer u_buffer (
    .in0_valid(valid0),
    .in1_valid(valid1),
    .*
  );

endmodule

`default_nettype wire

// File: source/dispatch_buffer.sv
//####################################################################
// two-entry in-order buffer between the decoders and the back end
// dispatches up to two per cycle and tells fetch how many to send
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module dispatch_buffer (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in0_valid,
  input  logic                      in1_valid,   // only with in0_valid
  input  dispatch_pkg::slot_count_t rob_free,
  input  dispatch_pkg::slot_count_t rs_free,
  input  decode_pkg::opa_sel_t      in0_opa_select, in1_opa_select,
  input  decode_pkg::opb_sel_t      in0_opb_select, in1_opb_select,
  input  decode_pkg::alu_func_t     in0_alu_func, in1_alu_func,
  input  decode_pkg::reg_idx_t      in0_ra_idx, in0_rb_idx, in0_dest_idx,
  input  decode_pkg::reg_idx_t      in1_ra_idx, in1_rb_idx, in1_dest_idx,
  input  logic                      in0_rd_mem, in0_wr_mem, in0_ldl_mem, in0_stc_mem,
  input  logic                      in0_cond_branch, in0_uncond_branch, in0_halt, in0_illegal,
  input  logic                      in1_rd_mem, in1_wr_mem, in1_ldl_mem, in1_stc_mem,
  input  logic                      in1_cond_branch, in1_uncond_branch, in1_halt, in1_illegal,
  output dispatch_pkg::slot_count_t dispatch_count,
  output dispatch_pkg::slot_count_t fetch_request,
  output decode_pkg::opa_sel_t      out0_opa_select, out1_opa_select,
  output decode_pkg::opb_sel_t      out0_opb_select, out1_opb_select,
  output decode_pkg::alu_func_t     out0_alu_func, out1_alu_func,
  output decode_pkg::reg_idx_t      out0_ra_idx, out0_rb_idx, out0_dest_idx,
  output decode_pkg::reg_idx_t      out1_ra_idx, out1_rb_idx, out1_dest_idx,
  output logic                      out0_rd_mem, out0_wr_mem, out0_ldl_mem, out0_stc_mem,
  output logic                      out0_cond_branch, out0_uncond_branch, out0_halt,
  output logic                      out0_illegal,
  output logic                      out1_rd_mem, out1_wr_mem, out1_ldl_mem, out1_stc_mem,
  output logic                      out1_cond_branch, out1_uncond_branch, out1_halt,
  output logic                      out1_illegal
);
  import decode_pkg::*;
  import dispatch_pkg::*;

  localparam int ENTRY_W = $bits(opa_sel_t) + $bits(opb_sel_t) + $bits(alu_func_t)
                         + 3 * $bits(reg_idx_t) + 8;  // 8 one-bit flags
  typedef logic [ENTRY_W-1:0] entry_t;  // one packed decode

  entry_t      entry_q [BUFFER_DEPTH];  // [0] oldest
  entry_t      entry_d [BUFFER_DEPTH];
  entry_t      in_entry [BUFFER_DEPTH];  // by fetch slot
  slot_count_t occupancy;
  slot_count_t remain;                   // entries left after dispatch
  slot_count_t valid_count;
  slot_count_t accept_count;

  assign in_entry[0] = {in0_opa_select, in0_opb_select, in0_alu_func, in0_ra_idx,
                        in0_rb_idx, in0_dest_idx, in0_rd_mem, in0_wr_mem, in0_ldl_mem,
                        in0_stc_mem, in0_cond_branch, in0_uncond_branch, in0_halt,
                        in0_illegal};
  assign in_entry[1] = {in1_opa_select, in1_opb_select, in1_alu_func, in1_ra_idx,
                        in1_rb_idx, in1_dest_idx, in1_rd_mem, in1_wr_mem, in1_ldl_mem,
                        in1_stc_mem, in1_cond_branch, in1_uncond_branch, in1_halt,
                        in1_illegal};
  assign {out0_opa_select, out0_opb_select, out0_alu_func, out0_ra_idx, out0_rb_idx,
          out0_dest_idx, out0_rd_mem, out0_wr_mem, out0_ldl_mem, out0_stc_mem,
          out0_cond_branch, out0_uncond_branch, out0_halt, out0_illegal} = entry_q[0];
  assign {out1_opa_select, out1_opb_select, out1_alu_func, out1_ra_idx, out1_rb_idx,
          out1_dest_idx, out1_rd_mem, out1_wr_mem, out1_ldl_mem, out1_stc_mem,
          out1_cond_branch, out1_uncond_branch, out1_halt, out1_illegal} = entry_q[1];

  // min of occupancy and both capacities
  always_comb
  begin
    dispatch_count = occupancy;
    if (rob_free < dispatch_count)
      dispatch_count = rob_free;
    if (rs_free < dispatch_count)
      dispatch_count = rs_free;
  end

  // state only, never fetch inputs
  assign fetch_request = slot_count_t'(BUFFER_DEPTH) - occupancy + dispatch_count;
  assign remain        = occupancy - dispatch_count;
  assign valid_count   = slot_count_t'(in0_valid) + slot_count_t'(in1_valid);
  assign accept_count  = (valid_count < fetch_request) ? valid_count : fetch_request;

  always_comb
  begin
    entry_d = entry_q;
    if (dispatch_count == 2'd1)
      entry_d[0] = entry_q[1];  // shift survivor to front
    if (remain == 2'd0)
    begin
      if (accept_count != 2'd0)
        entry_d[0] = in_entry[0];
      if (accept_count == 2'd2)
        entry_d[1] = in_entry[1];
    end
    else if (accept_count != 2'd0)
      entry_d[1] = in_entry[0];  // append behind held entry
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      occupancy <= '0;
    else
      occupancy <= remain + accept_count;
  end

  always_ff @(posedge clock)
  begin
    entry_q <= entry_d;
  end

  a_occupancy: assert property (@(posedge clock) disable iff (reset)
    occupancy <= slot_count_t'(BUFFER_DEPTH));
  a_fetch_order: assert property (@(posedge clock) disable iff (reset)
    in1_valid |-> in0_valid);
  a_capacity_range: assert property (@(posedge clock) disable iff (reset)
    rob_free <= MAX_CAPACITY && rs_free <= MAX_CAPACITY);
  a_dispatch_limit: assert property (@(posedge clock) disable iff (reset)
    dispatch_count <= rob_free && dispatch_count <= rs_free);

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
//####################################################################
// combinational decode of one fetch slot into datapath controls
// one instance per slot, outputs feed the dispatch buffer
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  decode_pkg::inst_t     inst,
  input  logic                  inst_valid,   // low gives noop controls
  output decode_pkg::opa_sel_t  opa_select,
  output decode_pkg::opb_sel_t  opb_select,
  output decode_pkg::alu_func_t alu_func,
  output decode_pkg::reg_idx_t  ra_idx,
  output decode_pkg::reg_idx_t  rb_idx,
  output decode_pkg::reg_idx_t  dest_idx,     // ZERO_REG if no writeback
  output logic                  rd_mem,
  output logic                  wr_mem,
  output logic                  ldl_mem,      // load-locked
  output logic                  stc_mem,      // store-conditional
  output logic                  cond_branch,
  output logic                  uncond_branch,
  output logic                  halt,
  output logic                  illegal
);
  import decode_pkg::*;

  opcode_t   opcode;
  int_func_t int_func;
  reg_idx_t  rc_idx;

  assign opcode   = inst[31:26];
  assign int_func = inst[11:5];
  assign rc_idx   = inst[4:0];
  assign ra_idx   = inst[25:21];
  assign rb_idx   = inst[20:16];

  always_comb
  begin
    opa_select    = OPA_REGA;
    opb_select    = OPB_REGB;
    alu_func      = ALU_ADDQ;
    dest_idx      = ZERO_REG;
    rd_mem        = 1'b0;
    wr_mem        = 1'b0;
    ldl_mem       = 1'b0;
    stc_mem       = 1'b0;
    cond_branch   = 1'b0;
    uncond_branch = 1'b0;
    halt          = 1'b0;
    illegal       = 1'b0;
    case (opcode)
      INTA_GRP, INTL_GRP, INTS_GRP, INTM_GRP:
      begin
        opb_select = inst[12] ? OPB_ALU_IMM : OPB_REGB;  // literal form
        dest_idx   = rc_idx;
        case ({opcode[1:0], int_func})  // group bits keep codes apart
          {2'd0, ADDQ_INST}:   alu_func = ALU_ADDQ;
          {2'd0, SUBQ_INST}:   alu_func = ALU_SUBQ;
          {2'd0, CMPEQ_INST}:  alu_func = ALU_CMPEQ;
          {2'd0, CMPLT_INST}:  alu_func = ALU_CMPLT;
          {2'd0, CMPLE_INST}:  alu_func = ALU_CMPLE;
          {2'd0, CMPULT_INST}: alu_func = ALU_CMPULT;
          {2'd0, CMPULE_INST}: alu_func = ALU_CMPULE;
          {2'd1, AND_INST}:    alu_func = ALU_AND;
          {2'd1, BIC_INST}:    alu_func = ALU_BIC;
          {2'd1, BIS_INST}:    alu_func = ALU_BIS;
          {2'd1, ORNOT_INST}:  alu_func = ALU_ORNOT;
          {2'd1, XOR_INST}:    alu_func = ALU_XOR;
          {2'd1, EQV_INST}:    alu_func = ALU_EQV;
          {2'd2, SRL_INST}:    alu_func = ALU_SRL;
          {2'd2, SLL_INST}:    alu_func = ALU_SLL;
          {2'd2, SRA_INST}:    alu_func = ALU_SRA;
          {2'd3, MULQ_INST}:   alu_func = ALU_MULQ;
          default:             illegal = 1'b1;
        endcase
      end
      JSR_GRP:
      begin
        opa_select    = OPA_NOT3;
        alu_func      = ALU_AND;      // clears low two bits of rb
        dest_idx      = ra_idx;       // return address
        uncond_branch = 1'b1;
      end
      LDA_INST, LDQ_INST, LDQ_L_INST, STQ_INST, STQ_C_INST:
      begin
        opa_select = OPA_MEM_DISP;    // address = disp + rb
        dest_idx   = (opcode == STQ_INST || opcode == STQ_C_INST) ? ZERO_REG : ra_idx;
        rd_mem     = (opcode == LDQ_INST || opcode == LDQ_L_INST);
        wr_mem     = (opcode == STQ_INST || opcode == STQ_C_INST);
        ldl_mem    = (opcode == LDQ_L_INST);
        stc_mem    = (opcode == STQ_C_INST);
      end
      BR_INST, BSR_INST:
      begin
        opa_select    = OPA_NPC;
        opb_select    = OPB_BR_DISP;
        dest_idx      = ra_idx;       // link register
        uncond_branch = 1'b1;
      end
      FBEQ_INST, FBLT_INST, FBLE_INST, FBNE_INST, FBGE_INST, FBGT_INST:
        illegal = 1'b1;               // no fp unit
      PAL_INST:
        if (inst[25:0] == PAL_HALT)
          halt = 1'b1;
        else
          illegal = 1'b1;
      default:
        if (opcode[5:3] == 3'b111)    // integer conditional branches
        begin
          opa_select  = OPA_NPC;
          opb_select  = OPB_BR_DISP;
          cond_branch = 1'b1;
        end
        else
          illegal = 1'b1;
    endcase
    // empty slot or illegal inst leaves a noop
    if (!inst_valid || illegal)
    begin
      opa_select    = OPA_REGA;
      opb_select    = OPB_REGB;
      alu_func      = ALU_ADDQ;
      dest_idx      = ZERO_REG;
      rd_mem        = 1'b0;
      wr_mem        = 1'b0;
      ldl_mem       = 1'b0;
      stc_mem       = 1'b0;
      cond_branch   = 1'b0;
      uncond_branch = 1'b0;
      halt          = 1'b0;
      illegal       = illegal & inst_valid;
    end
  end

endmodule

`default_nettype wire

// File: source/dispatch_pkg.sv
//####################################################################
// buffer depth and slot counts for dispatch flow control
//####################################################################
`default_nettype none

package dispatch_pkg;

  typedef logic [1:0] slot_count_t;  // 0 to 2 instructions

  // entries in the in-order dispatch buffer
  localparam int BUFFER_DEPTH = 2;

  // largest free-space value from rob or reservation stations
  localparam slot_count_t MAX_CAPACITY = 2'd2;

endpackage

`default_nettype wire

// File: source/decode_pkg.sv
//####################################################################
// instruction-set constants, field types and control codes for the
// alpha-subset decoders; imported inside module bodies
//####################################################################
`default_nettype none

package decode_pkg;

  typedef logic [31:0] inst_t;       // one instruction word
  typedef logic [4:0]  reg_idx_t;    // architectural register index
  typedef logic [4:0]  alu_func_t;   // ALU function code
  typedef logic [1:0]  opa_sel_t;    // operand A mux select
  typedef logic [1:0]  opb_sel_t;    // operand B mux select
  typedef logic [5:0]  opcode_t;     // inst[31:26]
  typedef logic [6:0]  int_func_t;   // inst[11:5], operate format

  localparam reg_idx_t ZERO_REG = 5'd31;  // dest when nothing written

  localparam opa_sel_t OPA_REGA     = 2'd0;
  localparam opa_sel_t OPA_MEM_DISP = 2'd1;
  localparam opa_sel_t OPA_NPC      = 2'd2;
  localparam opa_sel_t OPA_NOT3     = 2'd3;  // ~3 mask word-aligns the jump target

  localparam opb_sel_t OPB_REGB    = 2'd0;
  localparam opb_sel_t OPB_ALU_IMM = 2'd1;
  localparam opb_sel_t OPB_BR_DISP = 2'd2;

  localparam alu_func_t ALU_ADDQ   = 5'd0;
  localparam alu_func_t ALU_SUBQ   = 5'd1;
  localparam alu_func_t ALU_CMPEQ  = 5'd2;
  localparam alu_func_t ALU_CMPLT  = 5'd3;
  localparam alu_func_t ALU_CMPLE  = 5'd4;
  localparam alu_func_t ALU_CMPULT = 5'd5;
  localparam alu_func_t ALU_CMPULE = 5'd6;
  localparam alu_func_t ALU_AND    = 5'd7;
  localparam alu_func_t ALU_BIC    = 5'd8;
  localparam alu_func_t ALU_BIS    = 5'd9;
  localparam alu_func_t ALU_ORNOT  = 5'd10;
  localparam alu_func_t ALU_XOR    = 5'd11;
  localparam alu_func_t ALU_EQV    = 5'd12;
  localparam alu_func_t ALU_SRL    = 5'd13;
  localparam alu_func_t ALU_SLL    = 5'd14;
  localparam alu_func_t ALU_SRA    = 5'd15;
  localparam alu_func_t ALU_MULQ   = 5'd16;

  // opcodes
  localparam opcode_t PAL_INST   = 6'h00;
  localparam opcode_t LDA_INST   = 6'h08;
  localparam opcode_t INTA_GRP   = 6'h10;  // add, sub, compares
  localparam opcode_t INTL_GRP   = 6'h11;  // logicals
  localparam opcode_t INTS_GRP   = 6'h12;  // shifts
  localparam opcode_t INTM_GRP   = 6'h13;  // multiply
  localparam opcode_t JSR_GRP    = 6'h1a;  // jmp, jsr, ret, jsr_co
  localparam opcode_t LDQ_INST   = 6'h29;
  localparam opcode_t LDQ_L_INST = 6'h2b;
  localparam opcode_t STQ_INST   = 6'h2d;
  localparam opcode_t STQ_C_INST = 6'h2f;
  localparam opcode_t BR_INST    = 6'h30;
  localparam opcode_t FBEQ_INST  = 6'h31;
  localparam opcode_t FBLT_INST  = 6'h32;
  localparam opcode_t FBLE_INST  = 6'h33;
  localparam opcode_t BSR_INST   = 6'h34;
  localparam opcode_t FBNE_INST  = 6'h35;
  localparam opcode_t FBGE_INST  = 6'h36;
  localparam opcode_t FBGT_INST  = 6'h37;

  // operate function codes
  localparam int_func_t ADDQ_INST   = 7'h20;
  localparam int_func_t SUBQ_INST   = 7'h29;
  localparam int_func_t CMPEQ_INST  = 7'h2d;
  localparam int_func_t CMPLT_INST  = 7'h4d;
  localparam int_func_t CMPLE_INST  = 7'h6d;
  localparam int_func_t CMPULT_INST = 7'h1d;
  localparam int_func_t CMPULE_INST = 7'h3d;
  localparam int_func_t AND_INST    = 7'h00;
  localparam int_func_t BIC_INST    = 7'h08;
  localparam int_func_t BIS_INST    = 7'h20;
  localparam int_func_t ORNOT_INST  = 7'h28;
  localparam int_func_t XOR_INST    = 7'h40;
  localparam int_func_t EQV_INST    = 7'h48;
  localparam int_func_t SRL_INST    = 7'h34;
  localparam int_func_t SLL_INST    = 7'h39;
  localparam int_func_t SRA_INST    = 7'h3c;
  localparam int_func_t MULQ_INST   = 7'h20;

  localparam logic [25:0] PAL_HALT = 26'h0555;

endpackage

`default_nettype wire
